// ==== vlog.f ====
+incdir+include
hdl/icache_pkg.sv
hdl/sdp_ram.sv
hdl/icache.sv
hdl/fetch_top.sv
tests/tb_fetch_top.sv

// ==== Makefile ====
# Verilator build and run of the fetch subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_STR  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the status comes from the search for the pass line in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/icache_stim.txt ====
# op: 0 fetch, 1 store tag, 2 index invalidate, 3 hit invalidate; all columns hex
# op addr uncache tlb_exc cookie expected_data expected_exc expected_mem_reads
0 00001040 0 00 c0de0001 5a5a10445a5a1040 00 1
0 00001078 0 00 c0de0002 5a5a107c5a5a1078 00 0
0 00002040 0 00 c0de0003 5a5a20445a5a2040 00 1
0 00001050 0 00 c0de0004 5a5a10545a5a1050 00 0
0 00003040 0 00 c0de0005 5a5a30445a5a3040 00 1
0 00001048 0 00 c0de0006 5a5a104c5a5a1048 00 0
0 00002040 0 00 c0de0007 5a5a20445a5a2040 00 1
0 00003040 0 00 c0de0008 5a5a30445a5a3040 00 1
0 00002060 0 00 c0de0009 5a5a20645a5a2060 00 0
0 00001040 0 00 c0de000a 5a5a10445a5a1040 00 1
0 00001044 1 00 c0de000b 5a5a10445a5a1040 00 1
0 00001044 1 00 c0de000c 5a5a10445a5a1040 00 1
0 00008008 1 00 c0de000d 5a5a800c5a5a8008 00 1
0 00008008 0 00 c0de000e 5a5a800c5a5a8008 00 1
0 00008008 0 00 c0de000f 5a5a800c5a5a8008 00 0
0 00001042 0 00 c0de0010 0000000000000000 08 0
0 00001041 0 03 c0de0011 0000000000000000 03 0
0 00001040 0 21 c0de0012 0000000000000000 21 0
0 00001040 0 00 c0de0013 5a5a10445a5a1040 00 0
2 00001041 0 00 c0de0014 0000000000000000 00 0
0 00001040 0 00 c0de0015 5a5a10445a5a1040 00 1
0 00002040 0 00 c0de0016 5a5a20445a5a2040 00 1
3 00002040 0 00 c0de0017 0000000000000000 00 0
0 00002048 0 00 c0de0018 5a5a204c5a5a2048 00 1
0 00001040 0 00 c0de0019 5a5a10445a5a1040 00 1
1 00001040 0 00 c0de001a 0000000000000000 00 0
0 00001044 0 00 c0de001b 5a5a10445a5a1040 00 0
0 00002040 0 00 c0de001c 5a5a20445a5a2040 00 1
3 00005040 0 00 c0de001d 0000000000000000 00 0
0 00002040 0 00 c0de001e 5a5a20445a5a2040 00 0
3 00002040 0 05 c0de001f 0000000000000000 05 0
0 00002040 0 00 c0de0020 5a5a20445a5a2040 00 0
0 00abc0f8 0 00 c0de0021 5af1c0fc5af1c0f8 00 1
0 00abc0c0 0 00 c0de0022 5af1c0c45af1c0c0 00 0
0 00abc0c3 0 00 c0de0023 0000000000000000 08 0

// ==== tests/tb_fetch_top.sv ====
`timescale 1ns/1ns

module tb_fetch_top import icache_pkg::*; ();

    localparam int TIMEOUT = 50;   // cycles allowed per request

    logic     clk;
    logic     rstn;
    logic     i_rvalid;
    addr_t    i_raddr;
    addr_t    i_paddr;
    logic     i_uncache;
    cookie_t  i_cookie;
    logic     i_cacop_en;
    logic [1:0] i_cacop_code;
    exc_t     i_tlb_exc;
    logic     o_rready;
    dword_t   o_rdata;
    addr_t    o_pc;
    cookie_t  o_cookie;
    exc_t     o_exception;
    addr_t    o_badv;
    logic     o_cacop_ready;
    logic     o_cacop_complete;
    logic     o_mem_rvalid;
    addr_t    o_mem_raddr;
    logic     i_mem_rready;
    line_t    i_mem_rdata;

    int       errors = 0;
    int       n_req = 0;
    int       mem_reqs = 0;     // read requests seen by the memory model
    addr_t    last_mem_addr = '0;
    bit       abort = 1'b0;
    integer   seed = 32'h67b849a5;

    fetch_top fetch_top_i (
        .clk              (clk),
        .rstn             (rstn),
        .i_rvalid         (i_rvalid),
        .i_raddr          (i_raddr),
        .i_paddr          (i_paddr),
        .i_uncache        (i_uncache),
        .i_cookie         (i_cookie),
        .i_cacop_en       (i_cacop_en),
        .i_cacop_code     (i_cacop_code),
        .i_tlb_exc        (i_tlb_exc),
        .o_rready         (o_rready),
        .o_rdata          (o_rdata),
        .o_pc             (o_pc),
        .o_cookie         (o_cookie),
        .o_exception      (o_exception),
        .o_badv           (o_badv),
        .o_cacop_ready    (o_cacop_ready),
        .o_cacop_complete (o_cacop_complete),
        .o_mem_rvalid     (o_mem_rvalid),
        .o_mem_raddr      (o_mem_raddr),
        .i_mem_rready     (i_mem_rready),
        .i_mem_rdata      (i_mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // each word of memory holds its byte address xor 5a5a0000
    function automatic line_t mem_line(input addr_t a, input logic unc);
        line_t l;
        l = '0;
        if (unc) begin
            l[479:448] = a ^ 32'h5a5a0000;  // doubleword goes on top of the line
            l[511:480] = (a + 32'd4) ^ 32'h5a5a0000;
        end else begin
            for (int i = 0; i < 16; i++) begin
                l[i*32 +: 32] = (a + 32'(i * 4)) ^ 32'h5a5a0000;
            end
        end
        return l;
    endfunction

    // memory model answering after 0 to 5 idle cycles
    initial begin
        int delay;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        forever begin
            @(negedge clk);
            if (o_mem_rvalid === 1'b1) begin
                mem_reqs++;
                last_mem_addr = o_mem_raddr;
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                i_mem_rdata  <= mem_line(last_mem_addr, i_uncache);
                i_mem_rready <= 1'b1;
                @(posedge clk);
                i_mem_rready <= 1'b0;
            end
        end
    end

    task automatic report_mismatch(input string name, input string field,
                                   input logic [63:0] exp_v, input logic [63:0] act_v);
        $display("error %s %s expected %h actual %h", name, field, exp_v, act_v);
        errors++;
    endtask

    task automatic run_request(input logic [1:0] op, input addr_t addr, input logic unc,
                               input exc_t tlb, input cookie_t ck, input dword_t exp_data,
                               input exc_t exp_exc, input int exp_miss);
        string name;
        int    reqs_before;
        int    cycles;
        bit    got;
        bit    is_cacop;
        addr_t exp_badv;
        addr_t exp_mem_addr;
        name         = $sformatf("req %0d op %0d addr %h", n_req, op, addr);
        is_cacop     = (op != 2'd0);
        reqs_before  = mem_reqs;
        exp_badv     = (exp_exc != 7'h00) ? addr : 32'h0;
        exp_mem_addr = unc ? {addr[31:3], 3'b000} : {addr[31:6], 6'b000000};
        n_req++;

        @(posedge clk);
        i_rvalid     <= !is_cacop;
        i_cacop_en   <= is_cacop;
        i_cacop_code <= op - 2'd1;   // 1..3 map to codes 0..2
        i_raddr      <= addr;
        i_paddr      <= addr;         // no translation
        i_uncache    <= unc;
        i_tlb_exc    <= tlb;
        i_cookie     <= ck;
        @(negedge clk);
        if (o_cacop_ready !== 1'b1) begin
            report_mismatch(name, "ready", 64'(1'b1), 64'(o_cacop_ready));
        end
        @(posedge clk);              // taken here by the idle cache
        i_rvalid   <= 1'b0;
        i_cacop_en <= 1'b0;

        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (o_mem_rvalid === 1'b1 && o_cacop_ready !== 1'b0) begin
                report_mismatch(name, "ready in miss", 64'(1'b0), 64'(o_cacop_ready));
            end
            if (is_cacop ? o_cacop_complete : o_rready) begin
                got = 1'b1;
            end
        end
        if (!got) begin
            $display("timeout, the cache gave no response for %s", name);
            errors++;
            abort = 1'b1;
        end else begin
            if (o_exception !== exp_exc) begin
                report_mismatch(name, "exception", 64'(exp_exc), 64'(o_exception));
            end
            if (o_badv !== exp_badv) begin
                report_mismatch(name, "badv", 64'(exp_badv), 64'(o_badv));
            end
            if (!is_cacop && o_pc !== addr) begin
                report_mismatch(name, "pc", 64'(addr), 64'(o_pc));
            end
            if (!is_cacop && o_cookie !== ck) begin
                report_mismatch(name, "cookie", 64'(ck), 64'(o_cookie));
            end
            if (!is_cacop && exp_exc == 7'h00 && o_rdata !== exp_data) begin
                report_mismatch(name, "data", exp_data, o_rdata);
            end
            if (mem_reqs - reqs_before != exp_miss) begin
                report_mismatch(name, "memory reads", 64'(exp_miss),
                                64'(mem_reqs - reqs_before));
            end
            if (exp_miss != 0 && last_mem_addr !== exp_mem_addr) begin
                report_mismatch(name, "memory address", 64'(exp_mem_addr), 64'(last_mem_addr));
            end
        end
    endtask

    initial begin
        int          fd;
        int          rc;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_unc;
        logic [31:0] f_tlb;
        logic [31:0] f_cookie;
        logic [63:0] f_data;
        logic [31:0] f_exc;
        logic [31:0] f_miss;
        rstn         = 1'b0;
        i_rvalid     = 1'b0;
        i_raddr      = '0;
        i_paddr      = '0;
        i_uncache    = 1'b0;
        i_cookie     = '0;
        i_cacop_en   = 1'b0;
        i_cacop_code = 2'd0;
        i_tlb_exc    = '0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        if (o_rready !== 1'b0 || o_mem_rvalid !== 1'b0 || o_cacop_complete !== 1'b0) begin
            $display("outputs are not quiet after reset");
            errors++;
        end

        fd = $fopen("tests/icache_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tests/icache_stim.txt");
            errors++;
        end else begin
            while (!$feof(fd) && !abort) begin
                line = "";
                rc   = $fgets(line, fd);
                // comment and blank lines do not scan
                if (rc != 0 && $sscanf(line, "%h %h %h %h %h %h %h %h", f_op, f_addr, f_unc,
                                       f_tlb, f_cookie, f_data, f_exc, f_miss) == 8) begin
                    run_request(f_op[1:0], f_addr, f_unc[0], f_tlb[6:0], f_cookie, f_data,
                                f_exc[6:0], f_miss);
                end
            end
            $fclose(fd);
        end

        $display("requests %0d, memory reads %0d, errors %0d", n_req, mem_reqs, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top import icache_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    // pipeline side
    input  logic        i_rvalid,
    input  addr_t       i_raddr,
    input  addr_t       i_paddr,
    input  logic        i_uncache,
    input  cookie_t     i_cookie,
    input  logic        i_cacop_en,
    input  logic [1:0]  i_cacop_code,
    input  exc_t        i_tlb_exc,
    output logic        o_rready,
    output dword_t      o_rdata,
    output addr_t       o_pc,
    output cookie_t     o_cookie,
    output exc_t        o_exception,
    output addr_t       o_badv,
    output logic        o_cacop_ready,
    output logic        o_cacop_complete,
    // memory side
    output logic        o_mem_rvalid,
    output addr_t       o_mem_raddr,
    input  logic        i_mem_rready,
    input  line_t       i_mem_rdata
);

    index_t      rd_index;
    index_t      wr_index;
    tagv_t       tagv_wdata;
    line_t       line_wdata;
    logic [1:0]  tagv_we;
    logic [1:0]  data_we;
    tagv_t       tagv0;
    tagv_t       tagv1;
    line_t       line0;
    line_t       line1;

    icache icache_u (
        .clk              (clk),
        .rstn             (rstn),
        .i_rvalid         (i_rvalid),
        .i_raddr          (i_raddr),
        .i_paddr          (i_paddr),
        .i_uncache        (i_uncache),
        .i_cookie         (i_cookie),
        .i_cacop_en       (i_cacop_en),
        .i_cacop_code     (i_cacop_code),
        .i_tlb_exc        (i_tlb_exc),
        .o_rready         (o_rready),
        .o_rdata          (o_rdata),
        .o_pc             (o_pc),
        .o_cookie         (o_cookie),
        .o_exception      (o_exception),
        .o_badv           (o_badv),
        .o_cacop_ready    (o_cacop_ready),
        .o_cacop_complete (o_cacop_complete),
        .o_mem_rvalid     (o_mem_rvalid),
        .o_mem_raddr      (o_mem_raddr),
        .i_mem_rready     (i_mem_rready),
        .i_mem_rdata      (i_mem_rdata),
        .o_rd_index       (rd_index),
        .o_wr_index       (wr_index),
        .o_tagv_wdata     (tagv_wdata),
        .o_line_wdata     (line_wdata),
        .o_tagv_we        (tagv_we),
        .o_data_we        (data_we),
        .i_tagv0          (tagv0),
        .i_tagv1          (tagv1),
        .i_line0          (line0),
        .i_line1          (line1)
    );

    // tag arrays, one per way
    sdp_ram #(.DATA_W($bits(tagv_t)), .ADDR_W($bits(index_t))) tagv_ram0 (
        .clk     (clk),
        .i_raddr (rd_index),
        .i_waddr (wr_index),
        .i_din   (tagv_wdata),
        .i_we    (tagv_we[0]),
        .o_dout  (tagv0)
    );

    sdp_ram #(.DATA_W($bits(tagv_t)), .ADDR_W($bits(index_t))) tagv_ram1 (
        .clk     (clk),
        .i_raddr (rd_index),
        .i_waddr (wr_index),
        .i_din   (tagv_wdata),
        .i_we    (tagv_we[1]),
        .o_dout  (tagv1)
    );

    // data arrays, a whole line per entry
    sdp_ram #(.DATA_W($bits(line_t)), .ADDR_W($bits(index_t))) data_ram0 (
        .clk     (clk),
        .i_raddr (rd_index),
        .i_waddr (wr_index),
        .i_din   (line_wdata),
        .i_we    (data_we[0]),
        .o_dout  (line0)
    );

    sdp_ram #(.DATA_W($bits(line_t)), .ADDR_W($bits(index_t))) data_ram1 (
        .clk     (clk),
        .i_raddr (rd_index),
        .i_waddr (wr_index),
        .i_din   (line_wdata),
        .i_we    (data_we[1]),
        .o_dout  (line1)
    );

endmodule

// ==== hdl/icache.sv ====
`timescale 1ns/1ns
`include "icache_params.svh"

module icache import icache_pkg::*; (
    input  logic          clk,
    input  logic          rstn,
    // pipeline side
    input  logic          i_rvalid,
    input  addr_t         i_raddr,
    input  addr_t         i_paddr,
    input  logic          i_uncache,
    input  cookie_t       i_cookie,
    input  logic          i_cacop_en,
    input  logic [1:0]    i_cacop_code,
    input  exc_t          i_tlb_exc,
    output logic          o_rready,
    output dword_t        o_rdata,
    output addr_t         o_pc,
    output cookie_t       o_cookie,
    output exc_t          o_exception,
    output addr_t         o_badv,
    output logic          o_cacop_ready,
    output logic          o_cacop_complete,
    // memory side
    output logic          o_mem_rvalid,
    output addr_t         o_mem_raddr,
    input  logic          i_mem_rready,
    input  line_t         i_mem_rdata,
    // array side
    output index_t        o_rd_index,
    output index_t        o_wr_index,
    output tagv_t         o_tagv_wdata,
    output line_t         o_line_wdata,
    output logic [1:0]    o_tagv_we,
    output logic [1:0]    o_data_we,
    input  tagv_t         i_tagv0,
    input  tagv_t         i_tagv1,
    input  line_t         i_line0,
    input  line_t         i_line1
);

    icache_state_e state_q, state_d;

    // request buffers
    addr_t       req_addr_q;
    addr_t       paddr_q;
    cookie_t     cookie_q;
    logic        uncache_q;
    logic        cacop_q;
    logic [1:0]  cacop_code_q;
    line_t       ret_buf;

    logic        accept;        // take a new request this cycle
    logic        paddr_we;
    index_t      req_index;
    tag_t        req_tag;
    logic [1:0]  hit;
    logic [1:0]  hit_oh;
    logic        cache_hit;

    logic [`ICACHE_SETS-1:0] lru_q;  // most recently used way per set
    logic        lru_we;
    logic        lru_way;
    logic [1:0]  victim_oh;
    logic [1:0]  cacop_way;

    exc_t        adef_exc;
    exc_t        exc_now;
    line_t       line_sel;
    dword_t      dword_sel;

    assign req_index = req_addr_q[`ICACHE_OFF_W +: `ICACHE_INDEX_W];
    assign req_tag   = i_paddr[31 -: `ICACHE_TAG_W];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            uncache_q <= 1'b0;
            cacop_q   <= 1'b0;
        end else if (accept) begin
            uncache_q <= i_uncache;
            cacop_q   <= i_cacop_en;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q   <= i_raddr;
            cookie_q     <= i_cookie;
            cacop_code_q <= i_cacop_code;
        end
    end

    always_ff @(posedge clk) begin
        if (paddr_we) begin
            paddr_q <= i_paddr; // held for the miss request and the tag write
        end
    end

    // line coming back from memory
    always_ff @(posedge clk) begin
        if (o_mem_rvalid && i_mem_rready) begin
            ret_buf <= i_mem_rdata;
        end
    end

    // tags were read at the accepting edge
    assign hit[0]    = i_tagv0[`ICACHE_TAG_W] && (i_tagv0[`ICACHE_TAG_W-1:0] == req_tag);
    assign hit[1]    = i_tagv1[`ICACHE_TAG_W] && (i_tagv1[`ICACHE_TAG_W-1:0] == req_tag);
    assign hit_oh    = hit[0] ? 2'b01 : (hit[1] ? 2'b10 : 2'b00);
    assign cache_hit = |hit;

    // replace the way not used last
    assign victim_oh = lru_q[req_index] ? 2'b01 : 2'b10;
    assign cacop_way = req_addr_q[0] ? 2'b10 : 2'b01;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (lru_we) begin
            lru_q[req_index] <= lru_way;
        end
    end

    // a cache op has no alignment rule
    assign adef_exc = ((req_addr_q[1:0] != 2'b00) && !cacop_q) ? `EXP_ADEF : `EXP_NONE;
    assign exc_now  = (i_tlb_exc != `EXP_NONE) ? i_tlb_exc : adef_exc;

    // refill never follows an exception, so only lookup and cacop report one
    assign o_exception = ((state_q == st_lookup) || (state_q == st_cacop)) ? exc_now : `EXP_NONE;
    assign o_badv      = (o_exception != `EXP_NONE) ? req_addr_q : '0;

    // read data
    assign line_sel  = (state_q == st_refill) ? ret_buf : (hit_oh[1] ? i_line1 : i_line0);
    assign dword_sel = line_sel[req_addr_q[`ICACHE_OFF_W-1:3] * 64 +: 64];
    assign o_rdata   = uncache_q ? ret_buf[`ICACHE_LINE_W-1 -: 64] : dword_sel;
    assign o_pc      = req_addr_q;
    assign o_cookie  = cookie_q;

    // memory request
    assign o_mem_raddr = uncache_q ? {paddr_q[31:3], 3'b000}
                                   : {paddr_q[31:`ICACHE_OFF_W], {`ICACHE_OFF_W{1'b0}}};

    // arrays
    assign o_rd_index   = i_raddr[`ICACHE_OFF_W +: `ICACHE_INDEX_W];
    assign o_wr_index   = req_index;
    assign o_tagv_wdata = (state_q == st_cacop) ? '0 : {1'b1, paddr_q[31 -: `ICACHE_TAG_W]};
    assign o_line_wdata = ret_buf;

    assign o_cacop_ready = accept;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d          = state_q;
        accept           = 1'b0;
        paddr_we         = 1'b0;
        o_rready         = 1'b0;
        o_cacop_complete = 1'b0;
        o_mem_rvalid     = 1'b0;
        o_tagv_we        = 2'b00;
        o_data_we        = 2'b00;
        lru_we           = 1'b0;
        lru_way          = 1'b0;

        case (state_q)
            st_idle: begin
                accept = 1'b1;
            end
            st_lookup: begin
                if (exc_now != `EXP_NONE) begin
                    o_rready = 1'b1;    // fault reported without a memory access
                    state_d  = st_idle;
                end else begin
                    paddr_we = 1'b1;
                    if (uncache_q || !cache_hit) begin
                        state_d = st_miss;
                    end else begin
                        o_rready = 1'b1;
                        lru_we   = 1'b1;
                        lru_way  = hit_oh[1];
                        accept   = 1'b1;
                    end
                end
            end
            st_miss: begin
                o_mem_rvalid = 1'b1;
                if (i_mem_rready) begin
                    state_d = st_refill;
                end
            end
            st_refill: begin
                if (cacop_q) begin
                    o_cacop_complete = 1'b1;    // no array write after a cache op
                end else begin
                    o_rready = 1'b1;
                    if (!uncache_q) begin
                        o_tagv_we = victim_oh;
                        o_data_we = victim_oh;
                        lru_we    = 1'b1;
                        lru_way   = victim_oh[1];
                    end
                end
                accept = 1'b1;
            end
            st_cacop: begin
                if (exc_now != `EXP_NONE) begin
                    o_cacop_complete = 1'b1;
                    state_d          = st_idle;
                end else begin
                    case (cacop_code_q)
                        2'd0, 2'd1: o_tagv_we = cacop_way;  // store tag, index invalidate
                        2'd2:       o_tagv_we = hit_oh;     // hit invalidate
                        default:    o_tagv_we = 2'b00;
                    endcase
                    state_d = st_refill;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase

        if (accept) begin
            if (i_cacop_en) begin
                state_d = st_cacop;
            end else if (i_rvalid) begin
                state_d = st_lookup;
            end else begin
                state_d = st_idle;
            end
        end
    end

    // at most one way is written at a time
    a_we_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(o_tagv_we) && $onehot0(o_data_we));

    // memory request held with a stable address until taken
    a_mem_hold: assert property (@(posedge clk) disable iff (!rstn)
        (o_mem_rvalid && !i_mem_rready) |=> (o_mem_rvalid && $stable(o_mem_raddr)));

    // a response outside lookup only follows the memory handshake
    a_resp_after_mem: assert property (@(posedge clk) disable iff (!rstn)
        (o_rready && (state_q != st_lookup)) |-> $past(o_mem_rvalid && i_mem_rready));

endmodule

// ==== hdl/sdp_ram.sv ====
`timescale 1ns/1ns

module sdp_ram #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 6
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] i_raddr,
    input  logic [ADDR_W-1:0] i_waddr,
    input  logic [DATA_W-1:0] i_din,
    input  logic              i_we,
    output logic [DATA_W-1:0] o_dout
);

    logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];

    // all entries start out as zero, so every valid bit is clear
    initial begin
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        o_dout <= mem[i_raddr]; // read first, old data on collision
    end

endmodule

// ==== hdl/icache_pkg.sv ====
`include "icache_params.svh"

package icache_pkg;

    typedef logic [31:0]                    addr_t;
    typedef logic [63:0]                    dword_t;    // two instructions
    typedef logic [`ICACHE_LINE_W-1:0]      line_t;
    typedef logic [`ICACHE_TAG_W-1:0]       tag_t;
    typedef logic [`ICACHE_TAG_W:0]         tagv_t;     // valid on top
    typedef logic [`ICACHE_INDEX_W-1:0]     index_t;
    typedef logic [`ICACHE_COOKIE_W-1:0]    cookie_t;
    typedef logic [6:0]                     exc_t;

    // controller states
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss,
        st_refill,
        st_cacop
    } icache_state_e;

endpackage

// ==== include/icache_params.svh ====
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// cache geometry
`define ICACHE_INDEX_W     6
`define ICACHE_WORD_OFF_W  4
`define ICACHE_OFF_W       (`ICACHE_WORD_OFF_W + 2)          // byte offset in a line
`define ICACHE_SETS        (1 << `ICACHE_INDEX_W)
`define ICACHE_TAG_W       (32 - `ICACHE_INDEX_W - `ICACHE_OFF_W)
`define ICACHE_LINE_W      (32 << `ICACHE_WORD_OFF_W)        // 16 words of 32 bits

// request cookie carried back to the pipeline
`define ICACHE_COOKIE_W    32

// exception codes
`define EXP_NONE           7'h00
`define EXP_ADEF           7'h08

`endif
